// ==== alu_macros.svh ====
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// data path width of the unit.
`define ALU_WIDTH 8

// number of entries in the register file, indices are $clog2 of this.
`define ALU_NREGS 4

`endif

// ==== alu_pkg.sv ====
`include "alu_macros.svh"

package alu_pkg;

	// 4-bit opcode field encodings.
	typedef enum logic [3:0] {
		ALU_OP_ADD = 4'b0000,
		ALU_OP_SUB = 4'b0001,
		ALU_OP_ADC = 4'b0010, // add with stored carry.
		ALU_OP_SBC = 4'b0011, // subtract with stored carry as borrow.
		ALU_OP_AND = 4'b0100,
		ALU_OP_OR  = 4'b0101,
		ALU_OP_NOT = 4'b0110, // inverts the b operand.
		ALU_OP_XOR = 4'b0111,
		ALU_OP_SHL = 4'b1000,
		ALU_OP_SHR = 4'b1001,
		ALU_OP_SAL = 4'b1010, // same as shl.
		ALU_OP_SAR = 4'b1011,
		ALU_OP_ROL = 4'b1100,
		ALU_OP_ROR = 4'b1101,
		ALU_OP_RCL = 4'b1110, // rotate through carry.
		ALU_OP_RCR = 4'b1111
	} alu_op_e;

	typedef enum logic [1:0] {
		CLS_ALU_RR = 2'b00, // rd = rd op rs.
		CLS_ALU_RI = 2'b01, // rd = rd op imm.
		CLS_LDI    = 2'b10, // rd = imm, flags kept.
		CLS_RSVD   = 2'b11
	} instr_class_e;

	// incoming instruction word.
	typedef struct packed {
		instr_class_e                   cls;
		alu_op_e                        op;
		logic [$clog2(`ALU_NREGS)-1:0]  rd;  // destination and a operand.
		logic [$clog2(`ALU_NREGS)-1:0]  rs;  // b operand register.
		logic [`ALU_WIDTH-1:0]          imm;
	} instr_t;

	typedef struct packed {
		logic cf;
		logic zf;
		logic sf;
	} flags_t;

	// record held in the decode register.
	typedef struct packed {
		alu_op_e                        op;
		logic [$clog2(`ALU_NREGS)-1:0]  rd;
		logic [$clog2(`ALU_NREGS)-1:0]  rs;
		logic [`ALU_WIDTH-1:0]          imm;
		logic                           use_imm;
		logic                           is_ldi;
		logic                           illegal;
	} dec_t;

	// result record, also the writeback request.
	typedef struct packed {
		logic [$clog2(`ALU_NREGS)-1:0]  rd;
		logic [`ALU_WIDTH-1:0]          value;
		flags_t                         flags;
		logic                           illegal;
	} res_t;

endpackage

// ==== alu_decode.sv ====
`include "alu_macros.svh"

module alu_decode (
	input  logic            clk,
	input  logic            rst,
	input  logic            instr_valid,
	input  alu_pkg::instr_t instr,
	output logic            dec_valid,
	output alu_pkg::dec_t   dec
);

	import alu_pkg::*;

	dec_t dec_d;

	// class translation.
	always_comb
	begin
		dec_d.op      = instr.op;
		dec_d.rd      = instr.rd;
		dec_d.rs      = instr.rs;
		dec_d.imm     = instr.imm;
		dec_d.use_imm = (instr.cls == CLS_ALU_RI);
		dec_d.is_ldi  = (instr.cls == CLS_LDI);
		dec_d.illegal = (instr.cls == CLS_RSVD); // only place the reserved class is caught.
	end

	// strobe register.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= instr_valid;
		end
	end

	// payload register, loaded with the strobe.
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			dec <= dec_d;
		end
	end

endmodule

// ==== alu_execute.sv ====
`include "alu_macros.svh"

module alu_execute (
	input  logic                          dec_valid,
	input  alu_pkg::dec_t                 dec,
	output logic [$clog2(`ALU_NREGS)-1:0] rd_addr_a,
	output logic [$clog2(`ALU_NREGS)-1:0] rd_addr_b,
	input  logic [`ALU_WIDTH-1:0]         rd_data_a,
	input  logic [`ALU_WIDTH-1:0]         rd_data_b,
	input  alu_pkg::flags_t               flags,
	output logic                          exe_valid,
	output alu_pkg::res_t                 exe
);

	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] a;
	logic [`ALU_WIDTH-1:0] b;
	logic [`ALU_WIDTH:0]   a_ext;
	logic [`ALU_WIDTH:0]   b_ext;
	logic [`ALU_WIDTH:0]   c_ext;
	logic [`ALU_WIDTH:0]   tmp;  // bit 8 is the new carry.

	// register file read ports.
	assign rd_addr_a = dec.rd;
	assign rd_addr_b = dec.rs;

	assign a     = rd_data_a;
	assign b     = dec.use_imm ? dec.imm : rd_data_b;
	assign a_ext = {1'b0, a};
	assign b_ext = {1'b0, b};
	assign c_ext = {{`ALU_WIDTH{1'b0}}, flags.cf};

	always_comb
	begin
		case (dec.op)
			ALU_OP_ADD:
				tmp = a_ext + b_ext;
			ALU_OP_SUB:
				tmp = a_ext - b_ext; // borrow lands in bit 8.
			ALU_OP_ADC:
				tmp = a_ext + b_ext + c_ext;
			ALU_OP_SBC:
				tmp = a_ext - b_ext - c_ext;
			ALU_OP_AND:
				tmp = {1'b0, a & b};
			ALU_OP_OR:
				tmp = {1'b0, a | b};
			ALU_OP_NOT:
				tmp = {1'b0, ~b};
			ALU_OP_XOR:
				tmp = {1'b0, a ^ b};
			ALU_OP_SHL, ALU_OP_SAL:
				tmp = {a[`ALU_WIDTH-1], a[`ALU_WIDTH-2:0], 1'b0};
			ALU_OP_SHR:
				tmp = {a[0], 1'b0, a[`ALU_WIDTH-1:1]};
			ALU_OP_SAR:
				tmp = {a[0], a[`ALU_WIDTH-1], a[`ALU_WIDTH-1:1]}; // keeps the sign bit.
			ALU_OP_ROL:
				tmp = {a[`ALU_WIDTH-1], a[`ALU_WIDTH-2:0], a[`ALU_WIDTH-1]};
			ALU_OP_ROR:
				tmp = {a[0], a[0], a[`ALU_WIDTH-1:1]};
			ALU_OP_RCL:
				tmp = {a[`ALU_WIDTH-1], a[`ALU_WIDTH-2:0], flags.cf};
			ALU_OP_RCR:
				tmp = {a[0], flags.cf, a[`ALU_WIDTH-1:1]};
			default:
				tmp = '0;
		endcase
	end

	// result record for the writeback stage.
	always_comb
	begin
		exe.rd      = dec.rd;
		exe.illegal = dec.illegal;
		if (dec.illegal)
		begin
			exe.value = '0;
			exe.flags = flags;
		end
		else if (dec.is_ldi)
		begin
			exe.value = dec.imm; // flags pass through untouched.
			exe.flags = flags;
		end
		else
		begin
			exe.value    = tmp[`ALU_WIDTH-1:0];
			exe.flags.cf = tmp[`ALU_WIDTH];
			exe.flags.zf = (tmp[`ALU_WIDTH-1:0] == '0);
			exe.flags.sf = tmp[`ALU_WIDTH-1];
		end
	end

	assign exe_valid = dec_valid;

endmodule

// ==== alu_result.sv ====
`include "alu_macros.svh"

module alu_result (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          exe_valid,
	input  alu_pkg::res_t                 exe,
	input  logic [$clog2(`ALU_NREGS)-1:0] rd_addr_a,
	input  logic [$clog2(`ALU_NREGS)-1:0] rd_addr_b,
	output logic [`ALU_WIDTH-1:0]         rd_data_a,
	output logic [`ALU_WIDTH-1:0]         rd_data_b,
	output alu_pkg::flags_t               flags,
	output logic                          res_valid,
	output alu_pkg::res_t                 res
);

	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] regs [`ALU_NREGS];
	flags_t                flags_q;
	logic                  wr_en;

	assign wr_en = exe_valid && !exe.illegal;

	// register file and flag register.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `ALU_NREGS; i++)
			begin
				regs[i] <= '0;
			end
			flags_q <= '0;
		end
		else if (wr_en)
		begin
			regs[exe.rd] <= exe.value;
			flags_q      <= exe.flags; // ldi carries the old flags here.
		end
	end

	// combinational read, sees writes from the previous edge.
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];
	assign flags     = flags_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			res_valid <= 1'b0;
		end
		else
		begin
			res_valid <= exe_valid;
		end
	end

	// output record.
	always_ff @(posedge clk)
	begin
		if (exe_valid)
		begin
			res <= exe;
		end
	end

endmodule

// ==== alu_core.sv ====
`include "alu_macros.svh"

module alu_core (
	input  logic            clk,
	input  logic            rst,
	input  logic            instr_valid,
	input  alu_pkg::instr_t instr,
	output logic            res_valid,
	output alu_pkg::res_t   res
);

	import alu_pkg::*;

	logic                          dec_valid;
	dec_t                          dec;
	logic [$clog2(`ALU_NREGS)-1:0] rd_addr_a;
	logic [$clog2(`ALU_NREGS)-1:0] rd_addr_b;
	logic [`ALU_WIDTH-1:0]         rd_data_a;
	logic [`ALU_WIDTH-1:0]         rd_data_b;
	flags_t                        flags;
	logic                          exe_valid;
	res_t                          exe;

	alu_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec_valid   (dec_valid),
		.dec         (dec)
	);

	alu_execute u_execute (
		.dec_valid (dec_valid),
		.dec       (dec),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.flags     (flags),
		.exe_valid (exe_valid),
		.exe       (exe)
	);

	alu_result u_result (
		.clk       (clk),
		.rst       (rst),
		.exe_valid (exe_valid),
		.exe       (exe),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.flags     (flags),
		.res_valid (res_valid),
		.res       (res)
	);

endmodule

// ==== tb_alu_core.sv ====
`include "alu_macros.svh"

module tb_alu_core;

	timeunit 1ns;
	timeprecision 1ps;

	import alu_pkg::*;

	logic   clk = 1'b0;
	logic   rst;
	logic   instr_valid;
	instr_t instr;
	logic   res_valid;
	res_t   res;

	logic [`ALU_WIDTH-1:0] m_regs [`ALU_NREGS]; // architectural model state.
	flags_t                m_flags;
	logic [31:0]           lfsr_state = 32'hc67;
	res_t                  exp_q [$];
	int                    due_q [$];
	res_t                  exp_r;
	int                    due_c;
	int                    cyc = 0;
	int                    err_value = 0;
	int                    err_timing = 0;
	int                    err_proto = 0;

	alu_core u_dut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.res_valid   (res_valid),
		.res         (res)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// expected record, and the model moves on to the post-instruction state.
	function automatic res_t ref_exec(input instr_t ins);
		res_t                  r;
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
		logic [`ALU_WIDTH:0]   t;
		logic                  c;
		a = m_regs[ins.rd];
		b = (ins.cls == CLS_ALU_RI) ? ins.imm : m_regs[ins.rs];
		c = m_flags.cf;
		case (ins.op)
			ALU_OP_ADD: t = {1'b0, a} + {1'b0, b};
			ALU_OP_SUB: t = {1'b0, a} - {1'b0, b};
			ALU_OP_ADC: t = {1'b0, a} + {1'b0, b} + {8'd0, c};
			ALU_OP_SBC: t = {1'b0, a} - {1'b0, b} - {8'd0, c};
			ALU_OP_AND: t = {1'b0, a & b};
			ALU_OP_OR:  t = {1'b0, a | b};
			ALU_OP_NOT: t = {1'b0, ~b};
			ALU_OP_XOR: t = {1'b0, a ^ b};
			ALU_OP_SHL, ALU_OP_SAL: t = {a, 1'b0}; // msb falls into carry.
			ALU_OP_SHR: t = {a[0], a >> 1};
			ALU_OP_SAR: t = {a[0], $signed(a) >>> 1};
			ALU_OP_ROL: t = {a, a[7]};
			ALU_OP_ROR: t = {a[0], a[0], a[7:1]};
			ALU_OP_RCL: t = {a, c};
			ALU_OP_RCR: t = {a[0], c, a[7:1]};
			default:    t = '0;
		endcase
		r.rd      = ins.rd;
		r.illegal = (ins.cls == CLS_RSVD);
		if (r.illegal)
		begin
			r.value = '0;
			r.flags = m_flags;
		end
		else if (ins.cls == CLS_LDI)
		begin
			r.value = ins.imm;
			r.flags = m_flags;
			m_regs[ins.rd] = ins.imm;
		end
		else
		begin
			r.value    = t[7:0];
			r.flags.cf = t[8];
			r.flags.zf = (t[7:0] == 8'h00);
			r.flags.sf = t[7];
			m_regs[ins.rd] = r.value;
			m_flags = r.flags;
		end
		return r;
	endfunction

	function automatic instr_t make_instr(input instr_class_e cls, input alu_op_e op,
		input logic [1:0] rd, input logic [1:0] rs, input logic [7:0] imm);
		instr_t ins;
		ins.cls = cls;
		ins.op  = op;
		ins.rd  = rd;
		ins.rs  = rs;
		ins.imm = imm;
		return ins;
	endfunction

	function automatic instr_t random_instr();
		logic [31:0] v;
		instr_t      ins;
		v = rand_bits(2);
		ins.cls = instr_class_e'(v[1:0]);
		v = rand_bits(4);
		ins.op = alu_op_e'(v[3:0]);
		v = rand_bits(2);
		ins.rd = v[1:0];
		v = rand_bits(2);
		ins.rs = v[1:0];
		v = rand_bits(8);
		ins.imm = v[7:0];
		return ins;
	endfunction

	// strobe for one cycle, the dut samples it on the next edge.
	task automatic send_instr(input instr_t ins);
		@(posedge clk);
		instr_valid <= 1'b1;
		instr       <= ins;
		exp_q.push_back(ref_exec(ins));
		due_q.push_back(cyc + 3); // result seen two edges after the sampling edge.
	endtask

	task automatic load_imm(input logic [1:0] rd, input logic [7:0] imm);
		send_instr(make_instr(CLS_LDI, ALU_OP_ADD, rd, 2'd0, imm));
	endtask

	task automatic op_imm(input alu_op_e op, input logic [1:0] rd, input logic [7:0] imm);
		send_instr(make_instr(CLS_ALU_RI, op, rd, 2'd0, imm));
	endtask

	task automatic op_reg(input alu_op_e op, input logic [1:0] rd, input logic [1:0] rs);
		send_instr(make_instr(CLS_ALU_RR, op, rd, rs, 8'h00));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instr_valid <= 1'b0;
		end
	endtask

	task automatic drain_results();
		int n;
		n = 0;
		while (exp_q.size() > 0 && n < 20)
		begin
			@(posedge clk);
			n++;
		end
	endtask

	always @(posedge clk)
	begin
		if (res_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected result strobe at %0t with nothing outstanding", $time);
				err_proto++;
			end
			else
			begin
				exp_r = exp_q.pop_front();
				due_c = due_q.pop_front();
				if (res !== exp_r)
				begin
					$display("[ERROR] %0t: rd/val/flags/ill %0d/%h/%b/%b, expected %0d/%h/%b/%b",
						$time, res.rd, res.value, res.flags, res.illegal,
						exp_r.rd, exp_r.value, exp_r.flags, exp_r.illegal);
					err_value++;
				end
				if (cyc != due_c)
				begin
					$display("[ERROR] %0t: result at cycle %0d, expected cycle %0d",
						$time, cyc, due_c);
					err_timing++;
				end
			end
		end
		else if (due_q.size() > 0 && cyc >= due_q[0])
		begin
			$display("result missing at %0t, it was due at cycle %0d", $time, due_q[0]);
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
			err_proto++;
		end
	end

	initial
	begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		for (int i = 0; i < `ALU_NREGS; i++)
		begin
			m_regs[i] = '0;
		end
		m_flags = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		load_imm(2'd3, 8'hff); // set carry and zero so ldi has flags to keep.
		op_imm(ALU_OP_ADD, 2'd3, 8'h01);
		load_imm(2'd0, 8'h11);
		load_imm(2'd1, 8'ha5);
		load_imm(2'd2, 8'h00);
		load_imm(2'd3, 8'hff);
		for (int r = 0; r < 4; r++)
		begin
			op_imm(ALU_OP_ADD, r[1:0], 8'h00);
		end
		idle_cycles(2);

		op_reg(ALU_OP_ADD, 2'd0, 2'd1);
		op_imm(ALU_OP_ADD, 2'd3, 8'h02); // wraps past 255.
		op_reg(ALU_OP_SUB, 2'd1, 2'd0);
		load_imm(2'd2, 8'h40);
		op_imm(ALU_OP_SUB, 2'd2, 8'h40); // zero result.
		op_imm(ALU_OP_SUB, 2'd2, 8'h01);
		load_imm(2'd0, 8'hf0);
		load_imm(2'd1, 8'h20);
		op_reg(ALU_OP_ADD, 2'd0, 2'd1);
		op_reg(ALU_OP_ADC, 2'd1, 2'd1); // carry chain.
		op_imm(ALU_OP_ADC, 2'd0, 8'hff);
		op_reg(ALU_OP_SBC, 2'd1, 2'd0);
		op_imm(ALU_OP_SBC, 2'd0, 8'h7f);
		idle_cycles(2);

		for (int j = 0; j < 4; j++)
		begin
			for (int k = 4; k < 16; k++)
			begin
				load_imm(2'd0, j[1] ? 8'h4b : 8'h96);
				load_imm(2'd1, 8'h3c);
				load_imm(2'd3, 8'h00);
				op_imm(alu_op_e'(j[0] ? ALU_OP_SUB : ALU_OP_ADD), 2'd3, 8'h01); // carry in.
				op_reg(alu_op_e'(k[3:0]), 2'd0, 2'd1);
			end
		end
		idle_cycles(2);

		for (int i = 0; i < 16; i++)
		begin
			op_reg(alu_op_e'((i % 2 == 1) ? ALU_OP_ADC : ALU_OP_RCL), 2'd1, 2'd1);
			op_reg(ALU_OP_XOR, 2'd2, 2'd1);
		end
		idle_cycles(2);

		for (int r = 0; r < 4; r++)
		begin
			send_instr(make_instr(CLS_RSVD, alu_op_e'(r[3:0]), r[1:0], 2'd3, 8'h5a));
		end
		for (int r = 0; r < 4; r++)
		begin
			op_imm(ALU_OP_ADD, r[1:0], 8'h00);
		end
		idle_cycles(2);

		for (int i = 0; i < 300; i++)
		begin
			send_instr(random_instr());
		end
		idle_cycles(1);

		drain_results();
		if (exp_q.size() != 0)
		begin
			$display("timeout with %0d results still outstanding", exp_q.size());
			err_proto++;
		end
		$display("errors: value %0d, timing %0d, protocol %0d",
			err_value, err_timing, err_proto);
		if (err_value + err_timing + err_proto == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
alu_pkg.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_core.sv
tb_alu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module tb_alu_core -f sources.f -o tb_alu_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_alu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
	echo "simulation ended without a verdict"
	exit 1
fi
exit 0
